// File: gfx_settings.svh
`ifndef GFX_SETTINGS_SVH
`define GFX_SETTINGS_SVH

// horizontal timing in vga_clk cycles
// visible columns come after sync and back porch
`define GFX_H_VISIBLE 16
`define GFX_H_FRONT 2
`define GFX_H_SYNC 3
`define GFX_H_BACK 3

// vertical timing in lines
`define GFX_V_VISIBLE 8
`define GFX_V_FRONT 1
`define GFX_V_SYNC 2
`define GFX_V_BACK 2

// one 32-bit word holds four pixels
`define GFX_FB_WORDS 32

// scroll register sits right above the frame buffer
`define GFX_CONFIG_ADDR `GFX_FB_WORDS

`endif

// File: gfx_bus_pkg.sv
package gfx_bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0] byte_mask_t;
    typedef logic [3:0] nibble_t;

    localparam byte_mask_t MASK_NONE = 4'b0000;
    localparam byte_mask_t MASK_FULL = 4'b1111;
    // half-word masks select nibble expansion
    localparam byte_mask_t MASK_HALF_LO = 4'b0011;
    localparam byte_mask_t MASK_HALF_HI = 4'b1100;

    typedef struct packed {
        logic       read;
        logic       write;
        word_t      address;
        byte_mask_t mask;
        word_t      data_wr;
    } bus_req_t;

    typedef struct packed {
        word_t data_rd;
        logic  stall;
    } bus_rsp_t;

endpackage

// File: gfx_video_pkg.sv
`include "gfx_settings.svh"

package gfx_video_pkg;

    typedef logic [$clog2(`GFX_FB_WORDS)-1:0] fb_addr_t;

    // rgb 3-3-2, one byte per pixel
    typedef struct packed {
        logic [2:0] red;
        logic [2:0] green;
        logic [1:0] blue;
    } vga_color_t;

    typedef struct packed {
        vga_color_t color;
        logic       hsync;
        logic       vsync;
        logic       de;
    } vga_out_t;

endpackage

// File: gfx_framebuffer.sv
`include "gfx_settings.svh"

module gfx_framebuffer (
    input  logic                    clk_a_i,
    input  gfx_bus_pkg::byte_mask_t we_a_i,
    input  gfx_video_pkg::fb_addr_t addr_a_i,
    input  gfx_bus_pkg::word_t      din_a_i,
    output gfx_bus_pkg::word_t      dout_a_o,
    input  logic                    vga_clk,
    input  gfx_video_pkg::fb_addr_t addr_b_i,
    output gfx_bus_pkg::word_t      dout_b_o
);
    import gfx_bus_pkg::*;
    import gfx_video_pkg::*;

    localparam int BYTES = $bits(byte_mask_t);

    word_t mem [`GFX_FB_WORDS];

    // port a: bus side, byte-masked write, read returns old data
    always_ff @(posedge clk_a_i) begin
        for (int i = 0; i < BYTES; i++) begin
            if (we_a_i[i]) begin
                mem[addr_a_i][8*i +: 8] <= din_a_i[8*i +: 8];
            end
        end
        dout_a_o <= mem[addr_a_i];
    end

    // port b: display side, read only
    always_ff @(posedge vga_clk) begin
        dout_b_o <= mem[addr_b_i];
    end

endmodule

// File: gfx_bus_port.sv
`include "gfx_settings.svh"

module gfx_bus_port (
    input  logic                    bus_clk,
    input  logic                    rst,
    input  gfx_bus_pkg::bus_req_t   req_i,
    output gfx_bus_pkg::bus_rsp_t   rsp_o,
    output gfx_bus_pkg::byte_mask_t fb_we_o,
    output gfx_video_pkg::fb_addr_t fb_addr_o,
    output gfx_bus_pkg::word_t      fb_wdata_o,
    input  gfx_bus_pkg::word_t      fb_rdata_i,
    output gfx_bus_pkg::word_t      offset_o,
    input  gfx_bus_pkg::word_t      offset_sync_i
);
    import gfx_bus_pkg::*;
    import gfx_video_pkg::*;

    localparam int ADDR_W = $bits(fb_addr_t);

    logic       is_fb;
    logic       is_cfg;
    logic       half_mask;
    logic       last_stall;
    logic       fb_rd_done;
    word_t      cfg_rd_q;
    word_t      offset_q;
    byte_mask_t we_q;
    fb_addr_t   addr_q;
    word_t      wdata_q;

    // nibble is MSB first: byte 0 repeats bit 3
    function automatic word_t nibble_expand(input nibble_t bits);
        word_t w;
        w[7:0]   = {8{bits[3]}};
        w[15:8]  = {8{bits[2]}};
        w[23:16] = {8{bits[1]}};
        w[31:24] = {8{bits[0]}};
        return w;
    endfunction

    assign is_fb = req_i.address < 32'(`GFX_FB_WORDS);
    assign is_cfg = req_i.address == 32'(`GFX_CONFIG_ADDR);
    assign half_mask = (req_i.mask == MASK_HALF_LO) || (req_i.mask == MASK_HALF_HI);

    always_ff @(posedge bus_clk or posedge rst) begin
        if (rst) begin
            last_stall <= 1'b0;
            fb_rd_done <= 1'b0;
            we_q <= MASK_NONE;
            cfg_rd_q <= '0;
            offset_q <= '0;
        end else begin
            last_stall <= 1'b0;
            fb_rd_done <= 1'b0;
            we_q <= MASK_NONE;
            cfg_rd_q <= '0;
            if (req_i.write) begin
                if (is_fb) begin
                    we_q <= half_mask ? MASK_FULL : req_i.mask;
                end else if (is_cfg) begin
                    offset_q <= req_i.data_wr;
                end
            end else if (req_i.read) begin
                if (is_cfg) begin
                    cfg_rd_q <= offset_sync_i;
                end else if (is_fb) begin
                    // second edge of a held read picks up the ram output
                    if (last_stall) begin
                        fb_rd_done <= 1'b1;
                    end else begin
                        last_stall <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        if (req_i.write && is_fb) begin
            addr_q <= req_i.address[ADDR_W-1:0];
            wdata_q <= half_mask ? nibble_expand(req_i.data_wr[3:0]) : req_i.data_wr;
        end else if (req_i.read && is_fb && !last_stall) begin
            addr_q <= req_i.address[ADDR_W-1:0];
        end
    end

    assign fb_we_o = we_q;
    assign fb_addr_o = addr_q;
    assign fb_wdata_o = wdata_q;
    assign offset_o = offset_q;

    assign rsp_o.stall = last_stall;
    assign rsp_o.data_rd = fb_rd_done ? fb_rdata_i : cfg_rd_q;

endmodule

// File: gfx_offset_sync.sv
module gfx_offset_sync (
    input  logic               clk_i,
    input  logic               rst,
    input  gfx_bus_pkg::word_t d_i,
    output gfx_bus_pkg::word_t q_o
);
    import gfx_bus_pkg::*;

    word_t meta_q;
    word_t sync_q;

    // offset is written rarely, so a plain word-wide double flop is enough
    always_ff @(posedge clk_i or posedge rst) begin
        if (rst) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= d_i;
            sync_q <= meta_q;
        end
    end

    assign q_o = sync_q;

endmodule

// File: gfx_vga_timing.sv
`include "gfx_settings.svh"

module gfx_vga_timing (
    input  logic vga_clk,
    input  logic rst,
    output logic hsync_o,
    output logic vsync_o,
    output logic de_o
);

    localparam int H_TOTAL = `GFX_H_SYNC + `GFX_H_BACK + `GFX_H_VISIBLE + `GFX_H_FRONT;
    localparam int V_TOTAL = `GFX_V_SYNC + `GFX_V_BACK + `GFX_V_VISIBLE + `GFX_V_FRONT;

    typedef logic [$clog2(H_TOTAL)-1:0] hcount_t;
    typedef logic [$clog2(V_TOTAL)-1:0] vcount_t;

    localparam hcount_t H_LAST = hcount_t'(H_TOTAL - 1);
    localparam hcount_t H_SYNC_LAST = hcount_t'(`GFX_H_SYNC - 1);
    localparam hcount_t H_FIRST = hcount_t'(`GFX_H_SYNC + `GFX_H_BACK);
    localparam hcount_t H_END = hcount_t'(`GFX_H_SYNC + `GFX_H_BACK + `GFX_H_VISIBLE);
    localparam vcount_t V_LAST = vcount_t'(V_TOTAL - 1);
    localparam vcount_t V_SYNC_LAST = vcount_t'(`GFX_V_SYNC - 1);
    localparam vcount_t V_FIRST = vcount_t'(`GFX_V_SYNC + `GFX_V_BACK);
    localparam vcount_t V_END = vcount_t'(`GFX_V_SYNC + `GFX_V_BACK + `GFX_V_VISIBLE);

    hcount_t x;
    vcount_t y;
    logic    line_end;

    assign line_end = (x == H_LAST);

    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            x <= '0;
            y <= '0;
        end else if (line_end) begin
            x <= '0;
            y <= (y == V_LAST) ? '0 : y + 1'b1;
        end else begin
            x <= x + 1'b1;
        end
    end

    // sync levels line up with the counter values they describe
    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
        end else begin
            if (line_end) begin
                hsync_o <= 1'b1;
            end else if (x == H_SYNC_LAST) begin
                hsync_o <= 1'b0;
            end
            if (line_end && y == V_LAST) begin
                vsync_o <= 1'b1;
            end else if (line_end && y == V_SYNC_LAST) begin
                vsync_o <= 1'b0;
            end
        end
    end

    assign de_o = (x >= H_FIRST) && (x < H_END) && (y >= V_FIRST) && (y < V_END);

endmodule

// File: gfx_pixel_fetch.sv
`include "gfx_settings.svh"

module gfx_pixel_fetch (
    input  logic                      vga_clk,
    input  logic                      rst,
    input  logic                      de_i,
    input  gfx_bus_pkg::word_t        offset_i,
    output gfx_video_pkg::fb_addr_t   fb_addr_o,
    input  gfx_bus_pkg::word_t        fb_data_i,
    output gfx_video_pkg::vga_color_t color_o
);
    import gfx_bus_pkg::*;
    import gfx_video_pkg::*;

    localparam int PIXELS = `GFX_H_VISIBLE * `GFX_V_VISIBLE;
    localparam int ADDR_W = $bits(fb_addr_t);

    typedef logic [$clog2(PIXELS)-1:0] pix_t;

    localparam pix_t PIX_LAST = pix_t'(PIXELS - 1);

    pix_t     pix_q;
    fb_addr_t pixel_word;
    fb_addr_t offset_word;
    word_t    word_q;
    logic [4:0] byte_lsb;

    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            pix_q <= '0;
        end else if (de_i) begin
            pix_q <= (pix_q == PIX_LAST) ? '0 : pix_q + 1'b1;
        end
    end

    // look one word ahead so it is ready when the group of four starts
    assign pixel_word = pix_q[$bits(pix_t)-1:2];
    assign offset_word = offset_i[ADDR_W+1:2];
    // the address width wraps the sum at the frame-buffer depth
    assign fb_addr_o = pixel_word + offset_word + fb_addr_t'(1);

    // ram output belongs to the address of the previous cycle
    always_ff @(posedge vga_clk) begin
        if (de_i && pix_q[1:0] == 2'd3) begin
            word_q <= fb_data_i;
        end
    end

    // little endian with pixel 0 of a group in the low byte
    assign byte_lsb = {pix_q[1:0], 3'b000};
    assign color_o = vga_color_t'(word_q[byte_lsb +: 8]);

endmodule

// File: graphics_controller.sv
module graphics_controller (
    input  logic                    bus_clk,
    input  logic                    vga_clk,
    input  logic                    rst,
    input  gfx_bus_pkg::bus_req_t   bus_req_i,
    output gfx_bus_pkg::bus_rsp_t   bus_rsp_o,
    output gfx_video_pkg::vga_out_t vga_o
);
    import gfx_bus_pkg::*;
    import gfx_video_pkg::*;

    byte_mask_t fb_we;
    fb_addr_t   fb_addr_a;
    word_t      fb_wdata;
    word_t      fb_rdata_a;
    fb_addr_t   fb_addr_b;
    word_t      fb_rdata_b;
    word_t      offset_bus;
    word_t      offset_vga;
    word_t      offset_back;
    logic       hsync;
    logic       vsync;
    logic       de;
    vga_color_t color;

    gfx_bus_port u_bus_port (
        .bus_clk       (bus_clk),
        .rst           (rst),
        .req_i         (bus_req_i),
        .rsp_o         (bus_rsp_o),
        .fb_we_o       (fb_we),
        .fb_addr_o     (fb_addr_a),
        .fb_wdata_o    (fb_wdata),
        .fb_rdata_i    (fb_rdata_a),
        .offset_o      (offset_bus),
        .offset_sync_i (offset_back)
    );

    gfx_framebuffer u_framebuffer (
        .clk_a_i  (bus_clk),
        .we_a_i   (fb_we),
        .addr_a_i (fb_addr_a),
        .din_a_i  (fb_wdata),
        .dout_a_o (fb_rdata_a),
        .vga_clk  (vga_clk),
        .addr_b_i (fb_addr_b),
        .dout_b_o (fb_rdata_b)
    );

    // scroll offset into the video domain and back for readback
    gfx_offset_sync u_offset_to_vga (
        .clk_i (vga_clk),
        .rst   (rst),
        .d_i   (offset_bus),
        .q_o   (offset_vga)
    );

    gfx_offset_sync u_offset_to_bus (
        .clk_i (bus_clk),
        .rst   (rst),
        .d_i   (offset_vga),
        .q_o   (offset_back)
    );

    gfx_vga_timing u_vga_timing (
        .vga_clk (vga_clk),
        .rst     (rst),
        .hsync_o (hsync),
        .vsync_o (vsync),
        .de_o    (de)
    );

    gfx_pixel_fetch u_pixel_fetch (
        .vga_clk   (vga_clk),
        .rst       (rst),
        .de_i      (de),
        .offset_i  (offset_vga),
        .fb_addr_o (fb_addr_b),
        .fb_data_i (fb_rdata_b),
        .color_o   (color)
    );

    assign vga_o.color = color;
    assign vga_o.hsync = hsync;
    assign vga_o.vsync = vsync;
    assign vga_o.de = de;

endmodule

// File: tb_graphics_controller.sv
`include "gfx_settings.svh"

module tb_graphics_controller;
    timeunit 1ns;
    timeprecision 100ps;
    import gfx_bus_pkg::*;
    import gfx_video_pkg::*;

    localparam int H_TOTAL = `GFX_H_SYNC + `GFX_H_BACK + `GFX_H_VISIBLE + `GFX_H_FRONT;
    localparam int V_TOTAL = `GFX_V_SYNC + `GFX_V_BACK + `GFX_V_VISIBLE + `GFX_V_FRONT;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int PIXELS = `GFX_H_VISIBLE * `GFX_V_VISIBLE;
    // about twelve frames plus slack for the bus traffic
    localparam int TIMEOUT_CYCLES = 12 * FRAME_CYCLES + 256;

    logic     bus_clk;
    logic     vga_clk;
    logic     rst;
    bus_req_t req;
    bus_rsp_t rsp;
    vga_out_t vga;
    word_t    ref_mem [`GFX_FB_WORDS];
    int       errors;
    int       checks;
    int       tests;
    int       cycles;

    graphics_controller dut (
        .bus_clk   (bus_clk),
        .vga_clk   (vga_clk),
        .rst       (rst),
        .bus_req_i (req),
        .bus_rsp_o (rsp),
        .vga_o     (vga)
    );

    initial begin
        vga_clk = 1'b0;
        forever #4 vga_clk = ~vga_clk;
    end

    initial begin
        bus_clk = 1'b0;
        forever #6 bus_clk = ~bus_clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge vga_clk);
            cycles++;
        end
        $display("timeout: tests still running after %0d vga_clk cycles", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_color(input string name, input vga_color_t got, input vga_color_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("error at t=%0t: %s", $time, msg);
    endtask

    task automatic end_test(input string name, input int base);
        tests++;
        if (errors == base) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - base);
        end
    endtask

    // half masks spread the low nibble MSB first over whole bytes
    task automatic model_write(input word_t addr, input byte_mask_t mask, input word_t data);
        word_t      value;
        byte_mask_t en;
        if (addr >= `GFX_FB_WORDS) begin
            return;
        end
        en = mask;
        value = data;
        if (mask == MASK_HALF_LO || mask == MASK_HALF_HI) begin
            en = MASK_FULL;
            for (int k = 0; k < 4; k++) begin
                value[8*k +: 8] = data[3-k] ? 8'hFF : 8'h00;
            end
        end
        for (int k = 0; k < 4; k++) begin
            if (en[k]) begin
                ref_mem[int'(addr)][8*k +: 8] = value[8*k +: 8];
            end
        end
    endtask

    task automatic bus_write(input word_t addr, input byte_mask_t mask, input word_t data);
        @(negedge bus_clk);
        req.write = 1'b1;
        req.address = addr;
        req.mask = mask;
        req.data_wr = data;
        model_write(addr, mask, data);
        @(negedge bus_clk);
        req = '0;
    endtask

    task automatic read_fb(input word_t addr, output word_t data);
        @(negedge bus_clk);
        req.read = 1'b1;
        req.address = addr;
        @(negedge bus_clk);
        check_bit("bus_rsp.stall", rsp.stall, 1'b1);
        @(negedge bus_clk);
        check_bit("bus_rsp.stall", rsp.stall, 1'b0);
        data = rsp.data_rd;
        req = '0;
    endtask

    task automatic read_config(output word_t data);
        @(negedge bus_clk);
        req.read = 1'b1;
        req.address = word_t'(`GFX_CONFIG_ADDR);
        @(negedge bus_clk);
        check_bit("bus_rsp.stall", rsp.stall, 1'b0);
        data = rsp.data_rd;
        req = '0;
    endtask

    task automatic fill_random();
        for (int i = 0; i < `GFX_FB_WORDS; i++) begin
            bus_write(word_t'(i), MASK_FULL, $urandom);
        end
    endtask

    // returns on the first vga_clk sample of a frame
    task automatic wait_frame_start();
        logic prev;
        prev = 1'b1;
        @(negedge vga_clk);
        while (!(vga.vsync && !prev)) begin
            prev = vga.vsync;
            @(negedge vga_clk);
        end
    endtask

    task automatic test_reset_state();
        int base;
        base = errors;
        check_bit("bus_rsp.stall", rsp.stall, 1'b0);
        check_word("bus_rsp.data_rd", rsp.data_rd, '0);
        check_bit("vga.de", vga.de, 1'b0);
        check_bit("vga.hsync", vga.hsync, 1'b1);
        check_bit("vga.vsync", vga.vsync, 1'b1);
        end_test("reset state", base);
    endtask

    task automatic test_masked_rw();
        int         base;
        word_t      addr;
        byte_mask_t mask;
        word_t      data;
        word_t      got;
        base = errors;
        fill_random();
        for (int i = 0; i < 16; i++) begin
            addr = word_t'($urandom % `GFX_FB_WORDS);
            mask = byte_mask_t'($urandom % 16);
            data = $urandom;
            bus_write(addr, mask, data);
            read_fb(addr, got);
            check_word("bus_rsp.data_rd", got, ref_mem[int'(addr)]);
            @(negedge bus_clk);
            check_word("bus_rsp.data_rd (idle)", rsp.data_rd, '0);
        end
        end_test("masked writes", base);
    endtask

    task automatic write_and_expect(input word_t addr, input byte_mask_t mask,
                                    input word_t data, input word_t expected);
        word_t got;
        bus_write(addr, mask, data);
        read_fb(addr, got);
        check_word("bus_rsp.data_rd", got, expected);
    endtask

    task automatic test_nibble_expand();
        int         base;
        word_t      addr;
        byte_mask_t mask;
        word_t      got;
        base = errors;
        // upper data bits are ignored
        write_and_expect(32'd3, MASK_HALF_LO, 32'hFFFF_FFF8, 32'h0000_00FF);
        write_and_expect(32'd7, MASK_HALF_HI, 32'h0000_0001, 32'hFF00_0000);
        write_and_expect(32'd12, MASK_HALF_LO, 32'h1234_567A, 32'h00FF_00FF);
        write_and_expect(32'd20, MASK_HALF_HI, 32'hABCD_EF06, 32'h00FF_FF00);
        for (int i = 0; i < 4; i++) begin
            addr = word_t'($urandom % `GFX_FB_WORDS);
            mask = (i % 2 == 0) ? MASK_HALF_LO : MASK_HALF_HI;
            bus_write(addr, mask, $urandom);
            read_fb(addr, got);
            check_word("bus_rsp.data_rd", got, ref_mem[int'(addr)]);
        end
        end_test("nibble expansion", base);
    endtask

    task automatic test_scroll_readback();
        int    base;
        word_t value;
        word_t got;
        base = errors;
        value = $urandom;
        bus_write(word_t'(`GFX_CONFIG_ADDR), MASK_FULL, value);
        repeat (8) @(negedge bus_clk);
        read_config(got);
        check_word("bus_rsp.data_rd", got, value);
        end_test("scroll readback", base);
    endtask

    task automatic test_video_timing();
        int base;
        int de_cnt;
        int hs_cnt;
        int de_lines;
        int vs_lines;
        base = errors;
        de_lines = 0;
        vs_lines = 0;
        wait_frame_start();
        for (int line = 0; line < V_TOTAL; line++) begin
            de_cnt = 0;
            hs_cnt = 0;
            for (int x = 0; x < H_TOTAL; x++) begin
                if (line > 0 || x > 0) begin
                    @(negedge vga_clk);
                end
                if (x == 0 && vga.vsync) begin
                    vs_lines++;
                end
                if (vga.de) begin
                    de_cnt++;
                end
                if (vga.hsync) begin
                    hs_cnt++;
                end
            end
            if (de_cnt != 0 && de_cnt != `GFX_H_VISIBLE) begin
                report_error($sformatf("line %0d had de high for %0d cycles", line, de_cnt));
            end
            if (hs_cnt != `GFX_H_SYNC) begin
                report_error($sformatf("line %0d had hsync high for %0d cycles", line, hs_cnt));
            end
            if (de_cnt != 0) begin
                de_lines++;
            end
        end
        if (de_lines != `GFX_V_VISIBLE) begin
            report_error($sformatf("frame had %0d lines with de", de_lines));
        end
        if (vs_lines != `GFX_V_SYNC) begin
            report_error($sformatf("frame had vsync high for %0d lines", vs_lines));
        end
        end_test("video timing", base);
    endtask

    // pixel n shows byte n mod 4 of word (n/4 + offset/4) mod depth
    task automatic compare_frame(input word_t offset);
        int         n;
        int         idx;
        word_t      w;
        vga_color_t exp;
        n = 0;
        for (int c = 0; c < FRAME_CYCLES; c++) begin
            if (c > 0) begin
                @(negedge vga_clk);
            end
            if (vga.de) begin
                idx = (n / 4 + int'(offset / 4)) % `GFX_FB_WORDS;
                w = ref_mem[idx];
                exp = vga_color_t'(w[8*(n%4) +: 8]);
                check_color("vga.color", vga.color, exp);
                n++;
            end
        end
        if (n != PIXELS) begin
            report_error($sformatf("frame carried %0d pixels instead of %0d", n, PIXELS));
        end
    endtask

    task automatic test_pixel_stream();
        int    base;
        word_t offset;
        base = errors;
        fill_random();
        for (int k = 0; k < 2; k++) begin
            offset = (k == 0) ? 32'h0 : 32'(4 * (1 + $urandom % 31));
            bus_write(word_t'(`GFX_CONFIG_ADDR), MASK_FULL, offset);
            repeat (8) @(negedge bus_clk);
            wait_frame_start();
            wait_frame_start();
            compare_frame(offset);
        end
        end_test("pixel stream", base);
    endtask

    initial begin
        rst = 1'b1;
        req = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        void'($urandom(32'h0654_3765));
        repeat (2) @(negedge bus_clk);
        test_reset_state();
        rst = 1'b0;
        test_masked_rw();
        test_nibble_expand();
        test_scroll_readback();
        test_video_timing();
        test_pixel_stream();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: graphics_controller.f
+incdir+.
gfx_bus_pkg.sv
gfx_video_pkg.sv
gfx_framebuffer.sv
gfx_bus_port.sv
gfx_offset_sync.sv
gfx_vga_timing.sv
gfx_pixel_fetch.sv
graphics_controller.sv
tb_graphics_controller.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the graphics controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f graphics_controller.f \
    --top-module tb_graphics_controller \
    -o sim_graphics_controller

./obj_dir/sim_graphics_controller | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation reported errors"
    exit 1
fi

echo "simulation finished without errors"
